// ==== fifoBist.sv ====
//////////////////////////////
// FIFO source select and built-in self-test
//////////////////////////////
`timescale 1ns/10ps

module fifoBist
        import uartRxPkg::*;
(
        input  logic                 clk,
        input  logic                 rst,
        input  logic                 bistMode,
        input  logic [DATA_BITS-1:0] rxByte,
        input  logic                 rxValid,
        input  logic                 popData,
        input  logic [DATA_BITS-1:0] dataOut,
        input  logic                 fifoEmpty,
        input  logic                 fifoFull,
        output logic                 fifoWrite,
        output logic [DATA_BITS-1:0] fifoWData,
        output logic                 fifoPop,
        output logic                 bistDone,
        output logic                 bistPass
);

        bistState_t           state;
        logic [FIFO_WIDTH:0]  idx;                   // Fill and check index
        logic [DATA_BITS-1:0] patByte;
        logic [DATA_BITS-1:0] chkExp;
        logic                 chkValid;              // A check pop happened last cycle
        logic                 readBad;
        logic                 passOk;
        logic                 bistWrite;
        logic                 bistPop;

        assign patByte = DATA_BITS'(idx[FIFO_WIDTH-1:0]) ^ BIST_SEED;
        assign readBad = chkValid && (dataOut != chkExp);

        // Test mode owns the FIFO, receiver and host are cut off
        assign fifoWrite = bistMode ? bistWrite : rxValid;
        assign fifoWData = bistMode ? patByte : rxByte;
        assign fifoPop   = bistMode ? bistPop : popData;

        always_comb
        begin
                bistWrite = 1'b0;
                bistPop   = 1'b0;
                case (state)
                BIST_DRAIN: bistPop   = !fifoEmpty;
                BIST_FILL:  bistWrite = 1'b1;
                BIST_CHECK: bistPop   = (idx != FULL_COUNT);   // Last slot only compares
                default:    bistPop   = 1'b0;
                endcase
        end

        // Expected byte lines up with dataOut one cycle after the pop
        always_ff @(posedge clk)
        begin
                if (bistPop)
                        chkExp <= patByte;
        end

        //////////////////////////////
        // Test sequence
        always_ff @(posedge clk)
        begin
                if (rst || !bistMode)
                begin
                        state    <= BIST_IDLE;
                        idx      <= '0;
                        passOk   <= 1'b0;
                        chkValid <= 1'b0;
                        bistDone <= 1'b0;
                        bistPass <= 1'b0;
                end
                else
                begin
                        chkValid <= bistPop && (state == BIST_CHECK);
                        if (readBad)
                                passOk <= 1'b0;
                        case (state)
                        BIST_IDLE:
                        begin
                                passOk <= 1'b1;
                                idx    <= '0;
                                state  <= BIST_DRAIN;
                        end
                        BIST_DRAIN:
                        begin
                                if (fifoEmpty)
                                        state <= BIST_FILL;
                        end
                        BIST_FILL:
                        begin
                                idx <= idx + 1'b1;
                                if (idx == FULL_COUNT - 1'b1)
                                begin
                                        idx   <= '0;
                                        state <= BIST_CHECK;
                                end
                        end
                        BIST_CHECK:
                        begin
                                if ((idx == '0) && !fifoFull)
                                        passOk <= 1'b0;          // Fill did not reach full
                                if (idx == FULL_COUNT)
                                begin
                                        bistDone <= 1'b1;
                                        bistPass <= passOk && !readBad && fifoEmpty;
                                        state    <= BIST_DONE;
                                end
                                else
                                begin
                                        idx <= idx + 1'b1;
                                end
                        end
                        default: state <= BIST_DONE;     // Hold until bistMode drops
                        endcase
                end
        end

        bistPassNeedsDone: assert property (@(posedge clk) disable iff (rst)
                bistPass |-> bistDone);

endmodule

// ==== run.sh ====
#!/bin/sh
# Build and run the receive FIFO testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f tb.f --top-module tb -o simTb
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

out=$(./obj_dir/simTb 2>&1)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
    echo "Simulation exited with an error status"
    exit 1
fi

if printf '%s\n' "$out" | grep -qx "Simulation finished: PASS"; then
    exit 0
fi
echo "Pass line not found in the simulation output"
exit 1

// ==== rxFifo.sv ====
//////////////////////////////
// Receive FIFO, write wins over pop, sticky overflow
//////////////////////////////
`timescale 1ns/10ps

module rxFifo
        import uartRxPkg::*;
(
        input  logic                 clk,
        input  logic                 rst,
        input  logic                 fifoWrite,
        input  logic [DATA_BITS-1:0] fifoWData,
        input  logic                 fifoPop,
        output logic [DATA_BITS-1:0] dataOut,
        output logic                 fifoEmpty,
        output logic                 fifoHalfFull,
        output logic                 fifoFull,
        output logic                 fifoOverflow
);

        logic [DATA_BITS-1:0]  mem [FIFO_ENTRIES];
        logic [FIFO_WIDTH-1:0] rdPtr;
        logic [FIFO_WIDTH-1:0] wrPtr;
        logic [FIFO_WIDTH:0]   count;                // 0 to FIFO_ENTRIES
        logic [FIFO_WIDTH:0]   nextCount;
        logic                  isFull;
        logic                  doWrite;
        logic                  doPop;

        assign isFull  = (count == FULL_COUNT);
        assign doWrite = fifoWrite && !isFull;
        // A write in the same cycle blocks the pop
        assign doPop   = fifoPop && !fifoWrite && (count != '0);

        always_comb
        begin
                nextCount = count;
                if (doWrite)
                        nextCount = count + 1'b1;
                else if (doPop)
                        nextCount = count - 1'b1;
        end

        // Storage
        always_ff @(posedge clk)
        begin
                if (doWrite)
                        mem[wrPtr] <= fifoWData;
        end

        //////////////////////////////
        // Pointers, output byte and flags
        always_ff @(posedge clk)
        begin
                if (rst)
                begin
                        rdPtr        <= '0;
                        wrPtr        <= '0;
                        count        <= '0;
                        dataOut      <= '0;
                        fifoEmpty    <= 1'b1;
                        fifoHalfFull <= 1'b0;
                        fifoFull     <= 1'b0;
                        fifoOverflow <= 1'b0;
                end
                else
                begin
                        count        <= nextCount;
                        fifoEmpty    <= (nextCount == '0);   // Flags track the new count
                        fifoHalfFull <= (nextCount >= HALF_COUNT);
                        fifoFull     <= (nextCount == FULL_COUNT);
                        if (doWrite)
                                wrPtr <= wrPtr + 1'b1;
                        if (doPop)
                        begin
                                dataOut      <= mem[rdPtr];
                                rdPtr        <= rdPtr + 1'b1;
                                fifoOverflow <= 1'b0;          // A read frees room
                        end
                        else if (fifoWrite && isFull)
                        begin
                                fifoOverflow <= 1'b1;          // Byte is dropped
                        end
                end
        end

        fifoFlagsExclusive: assert property (@(posedge clk) disable iff (rst)
                !(fifoEmpty && fifoFull));

        fifoCountBound: assert property (@(posedge clk) disable iff (rst)
                count <= FULL_COUNT);

endmodule

// ==== tb.f ====
uartRxPkg.sv
uartRx.sv
rxFifo.sv
fifoBist.sv
uartRxTop.sv
tb.sv

// ==== tb.sv ====
//////////////////////////////
// Testbench for the receive FIFO subsystem with serial driver,
// FIFO model, checks and watchdog
//////////////////////////////
`timescale 1ns/10ps

module tb
        import uartRxPkg::*;
();

        localparam int CLK_PERIOD   = 100;
        localparam int IDLE_GAP     = 4;                  // High cycles after each stop bit
        localparam int ORDER_BYTES  = 40;
        localparam int ERR_FRAMES   = 6;
        // Order, overflow, framing (3 good plus errors), self-test (4 plus 2)
        localparam int TOTAL_FRAMES = ORDER_BYTES + FIFO_ENTRIES + 1 + 3 + ERR_FRAMES + 6;
        localparam int BIST_CYCLES  = 4 * FIFO_ENTRIES + 16;
        localparam int TIMEOUT_NS   =
                (TOTAL_FRAMES * 10 * CLKS_PER_BIT + BIST_CYCLES) * 2 * CLK_PERIOD;

        logic                 clk;
        logic                 rst;
        logic                 rxLine;
        logic                 popData;
        logic                 bistMode;
        logic [DATA_BITS-1:0] dataOut;
        logic                 fifoEmpty;
        logic                 fifoHalfFull;
        logic                 fifoFull;
        logic                 fifoOverflow;
        logic                 frameErr;
        logic                 bistDone;
        logic                 bistPass;

        // FIFO model
        logic [DATA_BITS-1:0] fifoModel [$];
        logic                 overflow;
        logic [DATA_BITS-1:0] lastOut;              // dataOut holds the last popped byte
        int                   errPulses;
        int unsigned          seedDummy;

        uartRxTop u_uartRxTop (
                .clk          (clk),
                .rst          (rst),
                .rxLine       (rxLine),
                .popData      (popData),
                .bistMode     (bistMode),
                .dataOut      (dataOut),
                .fifoEmpty    (fifoEmpty),
                .fifoHalfFull (fifoHalfFull),
                .fifoFull     (fifoFull),
                .fifoOverflow (fifoOverflow),
                .frameErr     (frameErr),
                .bistDone     (bistDone),
                .bistPass     (bistPass)
        );

        initial
        begin
                clk = 1'b0;
                forever #(CLK_PERIOD / 2) clk = ~clk;
        end

        always @(negedge clk)
        begin
                if (frameErr)
                        errPulses++;
        end

        initial
        begin
                #(TIMEOUT_NS);
                $display("Timeout: the tests did not finish in the expected time");
                $display("Simulation finished: FAIL");
                $fatal(1, "Watchdog expired");
        end

        //////////////////////////////
        // Checks
        task automatic checkValue(input string name, input logic [31:0] expected,
                                  input logic [31:0] actual);
                if (expected !== actual)
                begin
                        $display("FAILED %s: expected %0h, actual %0h", name, expected, actual);
                        $display("Simulation finished: FAIL");
                        $fatal(1, "Mismatch in %s", name);
                end
        endtask

        task automatic checkFlags(input string name);
                checkValue({name, " empty"}, 32'(fifoModel.size() == 0), 32'(fifoEmpty));
                checkValue({name, " half full"}, 32'(fifoModel.size() >= FIFO_ENTRIES / 2),
                           32'(fifoHalfFull));
                checkValue({name, " full"}, 32'(fifoModel.size() == FIFO_ENTRIES),
                           32'(fifoFull));
                checkValue({name, " overflow"}, 32'(overflow), 32'(fifoOverflow));
        endtask

        //////////////////////////////
        // Stimulus
        task automatic sendFrame(input logic [DATA_BITS-1:0] data, input logic stopBit);
                logic [DATA_BITS+1:0] frame;
                int                   i;
                frame = {stopBit, data, 1'b0};          // LSB goes out first
                for (i = 0; i < DATA_BITS + 2; i++)
                begin
                        @(negedge clk);
                        rxLine = frame[i];
                        repeat (CLKS_PER_BIT - 1) @(negedge clk);
                end
                @(negedge clk);
                rxLine = 1'b1;
                repeat (IDLE_GAP) @(negedge clk);
        endtask

        task automatic receiveFrame(input string name, input logic [DATA_BITS-1:0] data);
                int errBefore;
                errBefore = errPulses;
                sendFrame(data, 1'b1);
                if (fifoModel.size() < FIFO_ENTRIES)
                        fifoModel.push_back(data);
                else
                        overflow = 1'b1;                // Byte is lost and the flag sticks until a pop
                checkValue({name, " no frame error"}, 32'(errBefore), 32'(errPulses));
                checkFlags(name);
        endtask

        task automatic popOnce(input string name);
                logic [DATA_BITS-1:0] expData;
                @(negedge clk);
                popData = 1'b1;
                if (fifoModel.size() > 0)
                begin
                        lastOut  = fifoModel.pop_front();
                        overflow = 1'b0;
                end
                expData = lastOut;
                @(negedge clk);
                popData = 1'b0;
                checkValue({name, " data"}, 32'(expData), 32'(dataOut));
                checkFlags(name);
        endtask

        task automatic waitBistDone();
                while (!bistDone)
                        @(negedge clk);
        endtask

        //////////////////////////////
        // Test sequence
        initial
        begin
                int i;
                int sent;
                int burst;
                int pops;
                int errBefore;
                seedDummy = $urandom(24);
                rst       = 1'b1;
                rxLine    = 1'b1;
                popData   = 1'b0;
                bistMode  = 1'b0;
                overflow  = 1'b0;
                lastOut   = '0;
                errPulses = 0;
                repeat (10) @(negedge clk);
                rst = 1'b0;
                checkFlags("reset");

                // Byte order and flags with random bursts and pops
                sent = 0;
                while (sent < ORDER_BYTES)
                begin
                        burst = $urandom_range(1, 5);
                        for (i = 0; (i < burst) && (sent < ORDER_BYTES); i++)
                        begin
                                receiveFrame("order", DATA_BITS'($urandom()));
                                sent++;
                        end
                        pops = $urandom_range(0, 4);
                        for (i = 0; i < pops; i++)
                                popOnce("order");
                end
                while (fifoModel.size() > 0)
                        popOnce("order drain");

                // Overflow on the 17th byte
                for (i = 0; i <= FIFO_ENTRIES; i++)
                        receiveFrame("overflow", DATA_BITS'($urandom()));
                checkValue("overflow set", 32'(1), 32'(fifoOverflow));
                popOnce("overflow clear");
                while (fifoModel.size() > 0)
                        popOnce("overflow readback");
                popOnce("overflow empty pop");      // 17th byte must not appear

                // Framing errors leave the FIFO alone
                for (i = 0; i < 3; i++)
                        receiveFrame("framing fill", DATA_BITS'($urandom()));
                for (i = 0; i < ERR_FRAMES; i++)
                begin
                        errBefore = errPulses;
                        sendFrame(DATA_BITS'($urandom()), 1'b0);
                        checkValue("framing pulse", 32'(errBefore + 1), 32'(errPulses));
                        checkFlags("framing");
                end

                // Self-test on a partly filled FIFO
                for (i = 0; i < 4; i++)
                        receiveFrame("bist fill", DATA_BITS'($urandom()));
                @(negedge clk);
                bistMode = 1'b1;
                fifoModel.delete();
                overflow = 1'b0;
                lastOut  = DATA_BITS'(FIFO_ENTRIES - 1) ^ BIST_SEED;  // Last check read
                fork
                        sendFrame(DATA_BITS'($urandom()), 1'b1);  // Dropped in test mode
                        waitBistDone();
                join
                checkValue("bist done", 32'(1), 32'(bistDone));
                checkValue("bist pass", 32'(1), 32'(bistPass));
                checkValue("bist last read", 32'(lastOut), 32'(dataOut));
                checkFlags("bist end");
                @(negedge clk);
                bistMode = 1'b0;
                @(negedge clk);
                checkValue("bist done clear", 32'(0), 32'(bistDone));
                checkValue("bist pass clear", 32'(0), 32'(bistPass));
                receiveFrame("after bist", DATA_BITS'($urandom()));
                popOnce("after bist");

                $display("Simulation finished: PASS");
                $finish;
        end

endmodule

// ==== uartRx.sv ====
//////////////////////////////
// Serial line receiver, 8N1 frames, LSB first
//////////////////////////////
`timescale 1ns/10ps

module uartRx
        import uartRxPkg::*;
(
        input  logic                 clk,
        input  logic                 rst,
        input  logic                 rxLine,
        output logic [DATA_BITS-1:0] rxByte,
        output logic                 rxValid,
        output logic                 frameErr
);

        rxState_t             state;
        logic                 rxMeta;
        logic                 rxSync;
        logic                 rxPrev;               // Delayed copy for edge detect
        logic [CNT_WIDTH-1:0] bitClk;
        logic [IDX_WIDTH-1:0] bitIdx;

        // Two flops against metastability, a third to find the falling edge
        always_ff @(posedge clk)
        begin
                if (rst)
                begin
                        rxMeta <= 1'b1;             // Idle line is high
                        rxSync <= 1'b1;
                        rxPrev <= 1'b1;
                end
                else
                begin
                        rxMeta <= rxLine;
                        rxSync <= rxMeta;
                        rxPrev <= rxSync;
                end
        end

        //////////////////////////////
        // Frame FSM
        always_ff @(posedge clk)
        begin
                if (rst)
                begin
                        state    <= RX_IDLE;
                        bitClk   <= '0;
                        bitIdx   <= '0;
                        rxValid  <= 1'b0;
                        frameErr <= 1'b0;
                end
                else
                begin
                        rxValid  <= 1'b0;
                        frameErr <= 1'b0;
                        bitClk   <= bitClk + 1'b1;
                        case (state)
                        RX_IDLE:
                        begin
                                bitClk <= '0;
                                if (rxPrev && !rxSync)
                                        state <= RX_START;
                        end
                        RX_START:
                        begin
                                if (bitClk == BIT_MID)
                                begin
                                        bitClk <= '0;
                                        bitIdx <= '0;
                                        // High again at mid-bit means a glitch
                                        state  <= rxSync ? RX_IDLE : RX_DATA;
                                end
                        end
                        RX_DATA:
                        begin
                                if (bitClk == BIT_END)
                                begin
                                        bitClk <= '0;
                                        bitIdx <= bitIdx + 1'b1;
                                        if (bitIdx == LAST_BIT)
                                                state <= RX_STOP;
                                end
                        end
                        RX_STOP:
                        begin
                                if (bitClk == BIT_END)
                                begin
                                        rxValid  <= rxSync;   // Good stop bit
                                        frameErr <= !rxSync;
                                        state    <= RX_IDLE;
                                end
                        end
                        default: state <= RX_IDLE;
                        endcase
                end
        end

        // Data bits shift in from the top so bit 0 lands last at the bottom
        always_ff @(posedge clk)
        begin
                if ((state == RX_DATA) && (bitClk == BIT_END))
                        rxByte <= {rxSync, rxByte[DATA_BITS-1:1]};
        end

        rxStrobeExclusive: assert property (@(posedge clk) disable iff (rst)
                !(rxValid && frameErr));

endmodule

// ==== uartRxPkg.sv ====
//////////////////////////////
// Sizes, serial timing, BIST pattern and state enums
//////////////////////////////
package uartRxPkg;

        //////////////////////////////
        // FIFO sizing
        localparam int DATA_BITS    = 8;
        localparam int FIFO_WIDTH   = 4;                  // Pointer width
        localparam int FIFO_ENTRIES = 2 ** FIFO_WIDTH;

        // Entry counts need one bit more than the pointers
        localparam logic [FIFO_WIDTH:0] FULL_COUNT = (FIFO_WIDTH + 1)'(FIFO_ENTRIES);
        localparam logic [FIFO_WIDTH:0] HALF_COUNT = (FIFO_WIDTH + 1)'(FIFO_ENTRIES / 2);

        //////////////////////////////
        // Serial timing
        localparam int CLKS_PER_BIT = 16;                 // Kept small for short runs
        localparam int CNT_WIDTH    = $clog2(CLKS_PER_BIT);
        localparam int IDX_WIDTH    = $clog2(DATA_BITS);

        localparam logic [CNT_WIDTH-1:0] BIT_MID  = CNT_WIDTH'(CLKS_PER_BIT / 2 - 1);
        localparam logic [CNT_WIDTH-1:0] BIT_END  = CNT_WIDTH'(CLKS_PER_BIT - 1);
        localparam logic [IDX_WIDTH-1:0] LAST_BIT = IDX_WIDTH'(DATA_BITS - 1);

        // Self-test pattern, entry i holds i ^ BIST_SEED
        localparam logic [DATA_BITS-1:0] BIST_SEED = 8'hA5;

        //////////////////////////////
        // State machines
        typedef enum logic [1:0] {
                RX_IDLE,
                RX_START,
                RX_DATA,
                RX_STOP
        } rxState_t;

        typedef enum logic [2:0] {
                BIST_IDLE,
                BIST_DRAIN,
                BIST_FILL,
                BIST_CHECK,
                BIST_DONE
        } bistState_t;

endpackage

// ==== uartRxTop.sv ====
//////////////////////////////
// Receiver, self-test and FIFO
//////////////////////////////
`timescale 1ns/10ps

module uartRxTop
        import uartRxPkg::*;
(
        input  logic                 clk,
        input  logic                 rst,
        input  logic                 rxLine,
        input  logic                 popData,
        input  logic                 bistMode,
        output logic [DATA_BITS-1:0] dataOut,
        output logic                 fifoEmpty,
        output logic                 fifoHalfFull,
        output logic                 fifoFull,
        output logic                 fifoOverflow,
        output logic                 frameErr,
        output logic                 bistDone,
        output logic                 bistPass
);

        logic [DATA_BITS-1:0] rxByte;
        logic                 rxValid;
        logic [DATA_BITS-1:0] fifoWData;
        logic                 fifoWrite;
        logic                 fifoPop;

        uartRx u_uartRx (
                .clk      (clk),
                .rst      (rst),
                .rxLine   (rxLine),
                .rxByte   (rxByte),
                .rxValid  (rxValid),
                .frameErr (frameErr)
        );

        // Passes receiver and host through unless in test mode
        fifoBist u_fifoBist (
                .clk       (clk),
                .rst       (rst),
                .bistMode  (bistMode),
                .rxByte    (rxByte),
                .rxValid   (rxValid),
                .popData   (popData),
                .dataOut   (dataOut),
                .fifoEmpty (fifoEmpty),
                .fifoFull  (fifoFull),
                .fifoWrite (fifoWrite),
                .fifoWData (fifoWData),
                .fifoPop   (fifoPop),
                .bistDone  (bistDone),
                .bistPass  (bistPass)
        );

        rxFifo u_rxFifo (
                .clk          (clk),
                .rst          (rst),
                .fifoWrite    (fifoWrite),
                .fifoWData    (fifoWData),
                .fifoPop      (fifoPop),
                .dataOut      (dataOut),
                .fifoEmpty    (fifoEmpty),
                .fifoHalfFull (fifoHalfFull),
                .fifoFull     (fifoFull),
                .fifoOverflow (fifoOverflow)
        );

endmodule
